/* src/core_cfg.svh */
// width and size settings for the mini pipeline core
// included by the packages and by every module that sizes a port
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define DATA_W    16   // datapath and register width
`define REG_IDX_W 3    // register index bits
`define REG_CNT   8    // registers in the file
`define OPC_W     5    // opcode field, bits 15..11

`endif

/* src/isaPkg.sv */
// encoding of the 16-bit teaching ISA, opcodes, function codes and formats
`include "core_cfg.svh"

package isaPkg;

   // opcodes kept by this core, anything else is illegal
   typedef enum logic [`OPC_W-1:0] {
      OPC_RTYPE = 5'b11011,
      OPC_ADDI  = 5'b01000,
      OPC_SUBI  = 5'b01001,
      OPC_XORI  = 5'b01010,
      OPC_ANDNI = 5'b01011,
      OPC_LBI   = 5'b11000,
      OPC_SLBI  = 5'b10010
   } opcode_e;

   // register type function field, bits 1..0
   typedef enum logic [1:0] {
      FN_ADD  = 2'b00,
      FN_SUB  = 2'b01,   // rt - rs
      FN_XOR  = 2'b10,
      FN_ANDN = 2'b11    // rs & ~rt
   } func_e;

   typedef struct packed {
      opcode_e                opc;
      logic [`REG_IDX_W-1:0]  rs;
      logic [`REG_IDX_W-1:0]  rt;
      logic [`REG_IDX_W-1:0]  rd;
      func_e                  fn;
   } rFmt_t;

   typedef struct packed {
      opcode_e                opc;
      logic [`REG_IDX_W-1:0]  rs;
      logic [`REG_IDX_W-1:0]  rd;   // dest sits in 7..5 here
      logic [4:0]             imm;
   } iFmt_t;

   // lbi and slbi, rs doubles as the destination
   typedef struct packed {
      opcode_e                opc;
      logic [`REG_IDX_W-1:0]  rs;
      logic [7:0]             imm;
   } lFmt_t;

endpackage

/* src/pipePkg.sv */
// bundles passed between pipeline stages and the ALU operation encoding
`include "core_cfg.svh"

package pipePkg;

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,   // a + b + cin, also used for sub via invA
      ALU_XOR   = 3'd1,
      ALU_ANDN  = 3'd2,   // a & ~b
      ALU_PASSB = 3'd3,   // lbi
      ALU_SLBI  = 3'd4    // (a << 8) | b
   } aluOp_e;

   // decode -> execute
   typedef struct packed {
      logic                   valid;
      logic                   illegal;
      aluOp_e                 aluOp;
      logic                   invA;
      logic                   invB;
      logic                   cin;
      logic [`REG_IDX_W-1:0]  srcA;     // read index behind opA, for forwarding
      logic [`REG_IDX_W-1:0]  srcB;
      logic                   useImm;   // opB is an immediate, never forwarded
      logic [`DATA_W-1:0]     opA;
      logic [`DATA_W-1:0]     opB;
      logic [`REG_IDX_W-1:0]  dest;
      logic                   wrEn;
   } decoded_t;

   // execute -> result
   typedef struct packed {
      logic                   valid;
      logic                   illegal;
      logic                   wrEn;
      logic [`REG_IDX_W-1:0]  dest;
      logic [`DATA_W-1:0]     data;
   } result_t;

endpackage

/* src/regFile.sv */
// eight-entry register file, two async read ports and one write port
// a same-cycle write to the read index is returned on the read port
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module regFile (
   input  wire logic                   clk,
   input  wire logic                   arstN,
   input  wire logic [`REG_IDX_W-1:0]  rdIdxA,
   input  wire logic [`REG_IDX_W-1:0]  rdIdxB,
   output logic      [`DATA_W-1:0]     rdDataA,
   output logic      [`DATA_W-1:0]     rdDataB,
   input  wire logic                   wrEn,
   input  wire logic [`REG_IDX_W-1:0]  wrIdx,
   input  wire logic [`DATA_W-1:0]     wrData
);

   logic [`DATA_W-1:0] regs [`REG_CNT];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;   // every register reads zero after reset
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // write-through bypass, covers the instruction two slots behind decode
   assign rdDataA = (wrEn && (wrIdx == rdIdxA)) ? wrData : regs[rdIdxA];
   assign rdDataB = (wrEn && (wrIdx == rdIdxB)) ? wrData : regs[rdIdxB];

endmodule
`default_nettype wire

/* src/decodeStage.sv */
// combinational decode of one instruction into the execute bundle
// drives the register file read indices and folds in the read data
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module decodeStage (
   input  wire logic                   instrValid,
   input  wire logic [15:0]            instr,
   output logic      [`REG_IDX_W-1:0]  rdIdxA,
   output logic      [`REG_IDX_W-1:0]  rdIdxB,
   input  wire logic [`DATA_W-1:0]     rdDataA,
   input  wire logic [`DATA_W-1:0]     rdDataB,
   output pipePkg::decoded_t           decoded
);

   isaPkg::rFmt_t          rInst;
   isaPkg::iFmt_t          iInst;
   isaPkg::lFmt_t          lInst;
   pipePkg::aluOp_e        aluOp;
   logic                   invA, cin;
   logic                   useImm;
   logic                   useImm8;    // 8-bit immediate instead of 5-bit
   logic                   zeroExt;    // zero-extend rather than sign-extend
   logic                   legal;
   logic [`REG_IDX_W-1:0]  dest;
   logic [`DATA_W-1:0]     imm5, imm8;

   // same bits viewed through each format
   assign rInst = isaPkg::rFmt_t'(instr);
   assign iInst = isaPkg::iFmt_t'(instr);
   assign lInst = isaPkg::lFmt_t'(instr);

   always_comb begin
      aluOp   = pipePkg::ALU_ADD;
      invA    = 1'b0;
      cin     = 1'b0;
      useImm  = 1'b1;
      useImm8 = 1'b0;
      zeroExt = 1'b0;
      legal   = 1'b1;
      dest    = iInst.rd;
      case (rInst.opc)
         isaPkg::OPC_RTYPE: begin
            useImm = 1'b0;
            dest   = rInst.rd;
            case (rInst.fn)
               isaPkg::FN_ADD:  aluOp = pipePkg::ALU_ADD;
               isaPkg::FN_SUB: begin
                  invA = 1'b1;   // rt + ~rs + 1
                  cin  = 1'b1;
               end
               isaPkg::FN_XOR:  aluOp = pipePkg::ALU_XOR;
               isaPkg::FN_ANDN: aluOp = pipePkg::ALU_ANDN;
               default:         aluOp = pipePkg::ALU_ADD;
            endcase
         end
         isaPkg::OPC_ADDI: aluOp = pipePkg::ALU_ADD;
         isaPkg::OPC_SUBI: begin
            invA = 1'b1;   // imm - rs
            cin  = 1'b1;
         end
         isaPkg::OPC_XORI: begin
            aluOp   = pipePkg::ALU_XOR;
            zeroExt = 1'b1;
         end
         isaPkg::OPC_ANDNI: begin
            aluOp   = pipePkg::ALU_ANDN;
            zeroExt = 1'b1;
         end
         isaPkg::OPC_LBI: begin
            aluOp   = pipePkg::ALU_PASSB;
            useImm8 = 1'b1;
            dest    = lInst.rs;
         end
         isaPkg::OPC_SLBI: begin
            aluOp   = pipePkg::ALU_SLBI;   // port a carries old rs
            useImm8 = 1'b1;
            zeroExt = 1'b1;
            dest    = lInst.rs;
         end
         default: legal = 1'b0;
      endcase
   end

   // immediates, extension picked per opcode
   assign imm5 = zeroExt ? {{(`DATA_W-5){1'b0}}, iInst.imm}
                         : {{(`DATA_W-5){iInst.imm[4]}}, iInst.imm};
   assign imm8 = zeroExt ? {{(`DATA_W-8){1'b0}}, lInst.imm}
                         : {{(`DATA_W-8){lInst.imm[7]}}, lInst.imm};

   assign rdIdxA = rInst.rs;   // 10..8 in every format
   assign rdIdxB = rInst.rt;

   always_comb begin
      decoded         = '0;
      decoded.valid   = instrValid;
      decoded.illegal = instrValid & ~legal;
      decoded.wrEn    = instrValid & legal;   // illegal writes nothing
      decoded.aluOp   = aluOp;
      decoded.invA    = invA;
      // no kept instruction inverts b so invB keeps its cleared value
      decoded.cin     = cin;
      decoded.srcA    = rdIdxA;
      decoded.srcB    = rdIdxB;
      decoded.useImm  = useImm;
      decoded.opA     = rdDataA;
      decoded.opB     = !useImm ? rdDataB : (useImm8 ? imm8 : imm5);
      decoded.dest    = dest;
   end

endmodule
`default_nettype wire

/* src/pipeReg.sv */
// one pipeline register for any packed bundle
// reset clears the whole bundle so the valid bit drops with it
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
   parameter type payload_t = logic
) (
   input  wire logic  clk,
   input  wire logic  arstN,
   input  payload_t   d,
   output payload_t   q
);

   // no stall, samples every edge
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         q <= '0;
      end else begin
         q <= d;
      end
   end

endmodule
`default_nettype wire

/* src/aluExecute.sv */
// execute stage, forwards the previous result and runs the ALU
// combinational between the two pipeline registers
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module aluExecute (
   input  pipePkg::decoded_t  op,
   input  pipePkg::result_t   fwd,    // previous instruction, one slot ahead
   output pipePkg::result_t   res
);

   logic                fwdA, fwdB;
   logic [`DATA_W-1:0]  a, b;
   logic [`DATA_W-1:0]  aIn, bIn;
   logic [`DATA_W-1:0]  aluOut;

   // register value read in decode is stale if the previous instr wrote it
   assign fwdA = fwd.valid & fwd.wrEn & (fwd.dest == op.srcA);
   assign fwdB = fwd.valid & fwd.wrEn & ~op.useImm & (fwd.dest == op.srcB);

   assign a = fwdA ? fwd.data : op.opA;
   assign b = fwdB ? fwd.data : op.opB;

   assign aIn = op.invA ? ~a : a;
   assign bIn = op.invB ? ~b : b;

   always_comb begin
      case (op.aluOp)
         pipePkg::ALU_ADD:   aluOut = aIn + bIn + {{(`DATA_W-1){1'b0}}, op.cin};  // wraps
         pipePkg::ALU_XOR:   aluOut = aIn ^ bIn;
         pipePkg::ALU_ANDN:  aluOut = aIn & ~bIn;
         pipePkg::ALU_PASSB: aluOut = bIn;
         pipePkg::ALU_SLBI:  aluOut = (aIn << 8) | bIn;
         default:            aluOut = '0;
      endcase
   end

   // control bits ride through untouched
   always_comb begin
      res         = '0;
      res.valid   = op.valid;
      res.illegal = op.illegal;
      res.wrEn    = op.wrEn;
      res.dest    = op.dest;
      res.data    = aluOut;
   end

endmodule
`default_nettype wire

/* src/resultStage.sv */
// retires the execute bundle, writes the register file and reports it
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module resultStage (
   input  pipePkg::result_t         ret,
   output logic                     rfWrEn,
   output logic [`REG_IDX_W-1:0]    rfWrIdx,
   output logic [`DATA_W-1:0]       rfWrData,
   output logic                     wbValid,
   output logic [`REG_IDX_W-1:0]    wbReg,
   output logic [`DATA_W-1:0]       wbData,
   output logic                     illegal
);

   // write only for a live, legal instruction
   assign rfWrEn   = ret.valid & ret.wrEn & ~ret.illegal;
   assign rfWrIdx  = ret.dest;
   assign rfWrData = ret.data;

   assign wbValid  = rfWrEn;   // one strobe per retired write
   assign wbReg    = ret.dest;
   assign wbData   = ret.data;
   assign illegal  = ret.valid & ret.illegal;

endmodule
`default_nettype wire

/* src/miniCore.sv */
// top of the three-stage core, decode | execute | result
// instances and wires only, latency two clocks from instrValid
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module miniCore (
   input  wire logic                   clk,
   input  wire logic                   arstN,
   input  wire logic                   instrValid,
   input  wire logic [15:0]            instr,
   output logic                        wbValid,
   output logic      [`REG_IDX_W-1:0]  wbReg,
   output logic      [`DATA_W-1:0]     wbData,
   output logic                        illegal
);

   logic [`REG_IDX_W-1:0]  rdIdxA, rdIdxB;
   logic [`DATA_W-1:0]     rdDataA, rdDataB;
   logic                   rfWrEn;
   logic [`REG_IDX_W-1:0]  rfWrIdx;
   logic [`DATA_W-1:0]     rfWrData;
   pipePkg::decoded_t      decD, decQ;   // around the first register
   pipePkg::result_t       exD, exQ;     // around the second register

   regFile i_regFile (
      .clk(clk), .arstN(arstN),
      .rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .wrEn(rfWrEn), .wrIdx(rfWrIdx), .wrData(rfWrData)
   );

   decodeStage i_decodeStage (
      .instrValid(instrValid), .instr(instr),
      .rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .decoded(decD)
   );

   pipeReg #(.payload_t(pipePkg::decoded_t)) i_decReg (
      .clk(clk), .arstN(arstN), .d(decD), .q(decQ)
   );

   aluExecute i_aluExecute (
      .op(decQ), .fwd(exQ), .res(exD)   // exQ is the previous result
   );

   pipeReg #(.payload_t(pipePkg::result_t)) i_exReg (
      .clk(clk), .arstN(arstN), .d(exD), .q(exQ)
   );

   resultStage i_resultStage (
      .ret(exQ),
      .rfWrEn(rfWrEn), .rfWrIdx(rfWrIdx), .rfWrData(rfWrData),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .illegal(illegal)
   );

endmodule
`default_nettype wire

/* dv/miniCore_checker.sv */
// port-level assertions for miniCore, attached to every miniCore instance by bind
`timescale 1ns/1ps
`include "core_cfg.svh"

module miniCore_checker (
   input logic                 clk,
   input logic                 arstN,
   input logic                 instrValid,
   input logic                 wbValid,
   input logic                 illegal,
   input logic [`DATA_W-1:0]   wbData
);

   // a retired instruction either writes or traps
   strobeExclusive: assert property (@(posedge clk) disable iff (!arstN)
      !(wbValid && illegal))
      else $error("wbValid and illegal high in the same cycle");

   // fixed two cycle latency, nothing retires without a strobe behind it
   retireLatency: assert property (@(posedge clk) disable iff (!arstN)
      (wbValid || illegal) |-> $past(instrValid, 2))
      else $error("retire strobe without instrValid two cycles earlier");

   dataKnown: assert property (@(posedge clk) disable iff (!arstN)
      wbValid |-> !$isunknown(wbData))
      else $error("wbData unknown while wbValid is high");

endmodule

bind miniCore miniCore_checker i_checker (
   .clk(clk), .arstN(arstN), .instrValid(instrValid),
   .wbValid(wbValid), .illegal(illegal), .wbData(wbData)
);

/* dv/miniCore_tb.sv */
// directed testbench for miniCore, issues instructions against a reference register model
// results are matched in order from a queue, two cycles after each strobe
`timescale 1ns/1ps
`include "core_cfg.svh"

module miniCore_tb;

   typedef struct packed {
      logic                   illegal;
      logic [`REG_IDX_W-1:0]  dest;
      logic [`DATA_W-1:0]     data;
      logic [31:0]            due;      // cycle count at which the result shows
   } expect_t;

   localparam int MAX_CYCLES = 2000;   // tests need roughly 300

   logic                   clk, arstN, instrValid;
   logic [15:0]            instr;
   logic                   wbValid, illegal;
   logic [`REG_IDX_W-1:0]  wbReg;
   logic [`DATA_W-1:0]     wbData;
   logic [`DATA_W-1:0]     refRegs [`REG_CNT];   // architectural state as the ISA defines it
   expect_t                expQ [$];
   logic [31:0]            cycleCnt = '0;
   int                     errCnt;
   int                     seed;

   miniCore i_miniCore (
      .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
      .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .illegal(illegal)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // cycle count and watchdog
   always @(posedge clk) begin
      cycleCnt = cycleCnt + 1;
      if (cycleCnt >= MAX_CYCLES) begin
         $display("timeout, run stopped after %0d cycles", cycleCnt);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   task automatic reportMismatch(input string name, input logic [31:0] got, exp);
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errCnt++;
   endtask

   // outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      expect_t e;
      if (expQ.size() != 0 && expQ[0].due == cycleCnt) begin
         e = expQ.pop_front();
         if (e.illegal) begin
            if (illegal !== 1'b1) reportMismatch("illegal", 32'(illegal), 32'd1);
            if (wbValid !== 1'b0) reportMismatch("wbValid", 32'(wbValid), 32'd0);
         end else begin
            if (wbValid !== 1'b1) reportMismatch("wbValid", 32'(wbValid), 32'd1);
            if (illegal !== 1'b0) reportMismatch("illegal", 32'(illegal), 32'd0);
            if (wbReg !== e.dest) reportMismatch("wbReg", 32'(wbReg), 32'(e.dest));
            if (wbData !== e.data) reportMismatch("wbData", 32'(wbData), 32'(e.data));
         end
      end else if (wbValid !== 1'b0 || illegal !== 1'b0) begin
         $display("retire strobe seen with no instruction due, cycle %0d", cycleCnt);
         errCnt++;
      end
   end

   function automatic logic [15:0] rTypeInstr(input logic [1:0] fn,
                                               input logic [2:0] rs, rt, rd);
      return {isaPkg::OPC_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] immInstr(input logic [4:0] opc, input logic [2:0] rs, rd,
                                            input logic [4:0] imm);
      return {opc, rs, rd, imm};
   endfunction

   function automatic logic [15:0] byteInstr(input logic [4:0] opc, input logic [2:0] rs,
                                             input logic [7:0] imm);
      return {opc, rs, imm};
   endfunction

   // drives one strobe and predicts its result from the ISA rules
   task automatic issue(input logic [15:0] ins);
      expect_t            e;
      logic [`DATA_W-1:0] rs, rt, sx5, zx5, sx8, zx8;
      @(negedge clk);
      instrValid = 1'b1;
      instr      = ins;
      rs  = refRegs[ins[10:8]];
      rt  = refRegs[ins[7:5]];
      sx5 = {{11{ins[4]}}, ins[4:0]};
      zx5 = {11'b0, ins[4:0]};
      sx8 = {{8{ins[7]}}, ins[7:0]};
      zx8 = {8'b0, ins[7:0]};
      e      = '0;
      e.due  = cycleCnt + 2;   // two edges from decode to the result register
      e.dest = ins[7:5];
      case (ins[15:11])
         isaPkg::OPC_RTYPE: begin
            e.dest = ins[4:2];
            case (ins[1:0])
               2'b00:   e.data = rs + rt;
               2'b01:   e.data = rt - rs;
               2'b10:   e.data = rs ^ rt;
               default: e.data = rs & ~rt;
            endcase
         end
         isaPkg::OPC_ADDI:  e.data = rs + sx5;
         isaPkg::OPC_SUBI:  e.data = sx5 - rs;
         isaPkg::OPC_XORI:  e.data = rs ^ zx5;
         isaPkg::OPC_ANDNI: e.data = rs & ~zx5;
         isaPkg::OPC_LBI: begin
            e.dest = ins[10:8];
            e.data = sx8;
         end
         isaPkg::OPC_SLBI: begin
            e.dest = ins[10:8];
            e.data = (rs << 8) | zx8;
         end
         default: e.illegal = 1'b1;
      endcase
      if (!e.illegal) refRegs[e.dest] = e.data;
      expQ.push_back(e);
   endtask

   task automatic drain();
      @(negedge clk);
      instrValid = 1'b0;
      instr      = '0;
      while (expQ.size() != 0) @(negedge clk);   // watchdog bounds this
   endtask

   task automatic randomLegal(output logic [15:0] ins);
      logic [31:0] r;
      logic [4:0]  opc;
      r = $random(seed);
      case (r[31:29])
         3'd0:    opc = isaPkg::OPC_ADDI;
         3'd1:    opc = isaPkg::OPC_SUBI;
         3'd2:    opc = isaPkg::OPC_XORI;
         3'd3:    opc = isaPkg::OPC_ANDNI;
         3'd4:    opc = isaPkg::OPC_LBI;
         3'd5:    opc = isaPkg::OPC_SLBI;
         default: opc = isaPkg::OPC_RTYPE;   // every function code is legal
      endcase
      ins = {opc, r[10:0]};
   endtask

   task automatic loadRandom(input logic [2:0] r);
      logic [31:0] v;
      v = $random(seed);
      issue(byteInstr(isaPkg::OPC_LBI, r, v[15:8]));
      issue(byteInstr(isaPkg::OPC_SLBI, r, v[7:0]));   // high byte forwarded into slbi
   endtask

   task automatic resetAndLoad();
      for (int r = 0; r < `REG_CNT; r++) issue(immInstr(isaPkg::OPC_ADDI, 3'(r), 3'(r), 5'd0));
      issue(byteInstr(isaPkg::OPC_LBI, 3'd1, 8'h7f));
      issue(byteInstr(isaPkg::OPC_LBI, 3'd2, 8'h80));   // negative, sign-extends
      issue(byteInstr(isaPkg::OPC_LBI, 3'd3, 8'hff));
      drain();
   endtask

   task automatic regArith();
      logic [31:0] r;
      for (int i = 0; i < `REG_CNT; i++) loadRandom(3'(i));
      issue(byteInstr(isaPkg::OPC_LBI, 3'd6, 8'hff));   // 0xffff + 1 wraps
      issue(byteInstr(isaPkg::OPC_LBI, 3'd7, 8'h01));
      issue(rTypeInstr(isaPkg::FN_ADD, 3'd6, 3'd7, 3'd5));
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         issue(rTypeInstr(2'(i), r[2:0], r[5:3], r[8:6]));
      end
      drain();
   endtask

   task automatic immExtension();
      issue(byteInstr(isaPkg::OPC_LBI, 3'd1, 8'h40));
      issue(immInstr(isaPkg::OPC_ADDI, 3'd1, 3'd2, 5'h10));    // -16
      issue(immInstr(isaPkg::OPC_ADDI, 3'd1, 3'd3, 5'h0f));
      issue(immInstr(isaPkg::OPC_SUBI, 3'd1, 3'd4, 5'h13));    // -13 minus r1
      issue(immInstr(isaPkg::OPC_SUBI, 3'd2, 3'd4, 5'h07));
      issue(immInstr(isaPkg::OPC_XORI, 3'd1, 3'd5, 5'h1f));    // no sign bits
      issue(immInstr(isaPkg::OPC_ANDNI, 3'd4, 3'd6, 5'h15));
      issue(byteInstr(isaPkg::OPC_LBI, 3'd7, 8'hb2));
      issue(byteInstr(isaPkg::OPC_SLBI, 3'd7, 8'h9c));
      drain();
   endtask

   task automatic dependencies();
      issue(byteInstr(isaPkg::OPC_LBI, 3'd1, 8'd5));
      issue(immInstr(isaPkg::OPC_ADDI, 3'd1, 3'd2, 5'd3));        // a forwarded
      issue(rTypeInstr(isaPkg::FN_SUB, 3'd1, 3'd2, 3'd3));        // rt forwarded
      issue(rTypeInstr(isaPkg::FN_ADD, 3'd3, 3'd3, 3'd3));        // both sides
      issue(immInstr(isaPkg::OPC_ADDI, 3'd3, 3'd3, 5'h1e));
      issue(byteInstr(isaPkg::OPC_LBI, 3'd4, 8'hc3));
      issue(byteInstr(isaPkg::OPC_LBI, 3'd5, 8'h11));
      issue(rTypeInstr(isaPkg::FN_ADD, 3'd4, 3'd1, 3'd6));        // r4 through the bypass
      issue(rTypeInstr(isaPkg::FN_ANDN, 3'd2, 3'd5, 3'd7));       // r5 through the bypass
      drain();
   endtask

   task automatic illegalOps();
      issue({5'b00000, 11'h2a5});
      issue(byteInstr(isaPkg::OPC_LBI, 3'd2, 8'h33));
      issue({5'b11111, 11'h7ff});
      issue({5'b00111, 11'h0c1});
      issue(immInstr(isaPkg::OPC_ADDI, 3'd2, 3'd4, 5'd1));
      issue({5'b10101, 11'h3e4});
      drain();
      for (int r = 0; r < `REG_CNT; r++) issue(immInstr(isaPkg::OPC_ADDI, 3'(r), 3'(r), 5'd0));
      drain();
   endtask

   task automatic streaming();
      logic [15:0] ins;
      for (int i = 0; i < 60; i++) begin
         randomLegal(ins);
         issue(ins);
      end
      drain();
   endtask

   initial begin
      seed       = 32'h5af3_de92;
      errCnt     = 0;
      arstN      = 1'b0;
      instrValid = 1'b0;
      instr      = '0;
      for (int i = 0; i < `REG_CNT; i++) refRegs[i] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;
      resetAndLoad();
      regArith();
      immExtension();
      dependencies();
      illegalOps();
      streaming();
      $display("checks done, %0d errors", errCnt);
      if (errCnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/regFile.sv
src/decodeStage.sv
src/pipeReg.sv
src/aluExecute.sv
src/resultStage.sv
src/miniCore.sv
dv/miniCore_checker.sv
dv/miniCore_tb.sv

/* run.sh */
#!/bin/sh
# builds the miniCore testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module miniCore_tb -f sources.f -o simv
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
   exit 1
fi
exit 0
